//--- design/dot_array_pkg.sv
`default_nettype none

package dot_array_pkg;

	localparam int LANES = 32;

	// One Q8.8 element per lane
	localparam int ELEM_WIDTH = $bits(fixed_point_pkg::fixed_t);
	localparam int WORD_WIDTH = LANES * ELEM_WIDTH;

	// Lane i sits at bits [16i +: 16]
	typedef logic [WORD_WIDTH-1:0] lane_word_t;

	// Pairwise reduction of 32 lanes
	localparam int TREE_LEVELS = 5;

	// Multiplier register, tree stage register, output register
	localparam int PIPE_LATENCY = 3;

endpackage

`default_nettype wire

//--- design/dot_product_adder_tree.sv
`timescale 1ns/1ps
`default_nettype none

module dot_product_adder_tree (
	input  logic clk,
	input  logic reset,
	input  dot_array_pkg::lane_word_t products,
	output fixed_point_pkg::fixed_t data_out
);

	import fixed_point_pkg::*;
	import dot_array_pkg::*;

	// Node count per level of the pairwise tree
	localparam int L1_NODES = LANES >> 1;
	localparam int L2_NODES = LANES >> 2;
	localparam int L3_NODES = LANES >> 3;
	localparam int L4_NODES = LANES >> 4;

	fixed_t level1 [L1_NODES];
	fixed_t level2 [L2_NODES];
	fixed_t stage_q [L2_NODES];
	fixed_t level3 [L3_NODES];
	fixed_t level4 [L4_NODES];
	fixed_t level5;

	// Level 1 pairs lanes (0,1), (2,3) ... (30,31)
	for (genvar i = 0; i < L1_NODES; i++) begin : g_level1
		fixed_add_sat u_add (
			.a(products[(2*i)*ELEM_WIDTH +: ELEM_WIDTH]),
			.b(products[(2*i+1)*ELEM_WIDTH +: ELEM_WIDTH]),
			.c(level1[i])
		);
	end

	for (genvar i = 0; i < L2_NODES; i++) begin : g_level2
		fixed_add_sat u_add (
			.a(level1[2*i]),
			.b(level1[2*i+1]),
			.c(level2[i])
		);
	end

	// Pipeline cut after level 2
	always_ff @(posedge clk) begin
		if (!reset) begin
			stage_q <= '{default: '0};
		end else begin
			stage_q <= level2;
		end
	end

	// Levels 3 to 5 run off the stage registers
	for (genvar i = 0; i < L3_NODES; i++) begin : g_level3
		fixed_add_sat u_add (
			.a(stage_q[2*i]),
			.b(stage_q[2*i+1]),
			.c(level3[i])
		);
	end

	for (genvar i = 0; i < L4_NODES; i++) begin : g_level4
		fixed_add_sat u_add (
			.a(level3[2*i]),
			.b(level3[2*i+1]),
			.c(level4[i])
		);
	end

	// Final pair
	fixed_add_sat u_add_level5 (
		.a(level4[0]),
		.b(level4[1]),
		.c(level5)
	);

	always_ff @(posedge clk) begin
		if (!reset) begin
			data_out <= '0;
		end else begin
			data_out <= level5;
		end
	end

endmodule

`default_nettype wire

//--- design/fixed_add_sat.sv
`timescale 1ns/1ps
`default_nettype none

module fixed_add_sat (
	input  fixed_point_pkg::fixed_t a,
	input  fixed_point_pkg::fixed_t b,
	output fixed_point_pkg::fixed_t c
);

	import fixed_point_pkg::*;

	localparam int SIGN_BIT = FIXED_WIDTH - 1;

	fixed_t raw_sum;
	logic overflow;

	// Plain wrapping sum
	assign raw_sum = a + b;

	// Overflow only when operands agree in sign and the sum does not
	assign overflow = (a[SIGN_BIT] == b[SIGN_BIT]) && (raw_sum[SIGN_BIT] != a[SIGN_BIT]);

	always_comb begin
		if (!overflow) begin
			c = raw_sum;
		end else if (a[SIGN_BIT]) begin
			c = FIXED_MIN;
		end else begin
			c = FIXED_MAX;
		end
	end

endmodule

`default_nettype wire

//--- design/fixed_point_pkg.sv
`default_nettype none

package fixed_point_pkg;

	// Q8.8 element with a sign bit, 7 integer bits and 8 fraction bits
	localparam int FIXED_WIDTH = 16;
	localparam int FRAC_BITS = 8;

	// Full product of two Q8.8 values is Q16.16
	localparam int PRODUCT_WIDTH = 2 * FIXED_WIDTH;

	typedef logic signed [FIXED_WIDTH-1:0] fixed_t;
	typedef logic signed [PRODUCT_WIDTH-1:0] product_t;

	// Saturation limits of about +127.996 and -128.0
	localparam fixed_t FIXED_MAX = fixed_t'(32767);
	localparam fixed_t FIXED_MIN = fixed_t'(-32768);

endpackage

`default_nettype wire

//--- design/lane_multiplier_array.sv
`timescale 1ns/1ps
`default_nettype none

module lane_multiplier_array (
	input  logic clk,
	input  logic reset,
	input  dot_array_pkg::lane_word_t vector,
	input  dot_array_pkg::lane_word_t matrix,
	output dot_array_pkg::lane_word_t products
);

	import dot_array_pkg::*;

	// One registered multiplier per lane with results in lane order
	for (genvar lane = 0; lane < LANES; lane++) begin : g_lane
		signed_fixed_mul u_mul (
			.clk(clk),
			.reset(reset),
			.a(vector[lane*ELEM_WIDTH +: ELEM_WIDTH]),
			.b(matrix[lane*ELEM_WIDTH +: ELEM_WIDTH]),
			.c(products[lane*ELEM_WIDTH +: ELEM_WIDTH])
		);
	end

endmodule

`default_nettype wire

//--- design/signed_fixed_mul.sv
`timescale 1ns/1ps
`default_nettype none

module signed_fixed_mul (
	input  logic clk,
	input  logic reset,
	input  fixed_point_pkg::fixed_t a,
	input  fixed_point_pkg::fixed_t b,
	output fixed_point_pkg::fixed_t c
);

	import fixed_point_pkg::*;

	product_t full_product;
	product_t shifted_product;
	fixed_t sat_product;

	// Both operands signed, so the multiply is signed at 32 bits
	assign full_product = a * b;

	// Back to Q8.8 with truncation toward minus infinity
	assign shifted_product = full_product >>> FRAC_BITS;

	always_comb begin
		if (shifted_product > product_t'(FIXED_MAX)) begin
			sat_product = FIXED_MAX;
		end else if (shifted_product < product_t'(FIXED_MIN)) begin
			sat_product = FIXED_MIN;
		end else begin
			sat_product = fixed_t'(shifted_product);
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			c <= '0;
		end else begin
			c <= sat_product;
		end
	end

endmodule

`default_nettype wire

//--- design/vecmat_dot_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vecmat_dot_unit (
	input  logic clk,
	input  logic reset,
	input  dot_array_pkg::lane_word_t vector,
	input  dot_array_pkg::lane_word_t matrix,
	output fixed_point_pkg::fixed_t data_out
);

	import dot_array_pkg::*;

	// Registered per-lane products
	lane_word_t products;

	// Softmax row times V column, lane by lane
	lane_multiplier_array u_mul_array (
		.clk(clk),
		.reset(reset),
		.vector(vector),
		.matrix(matrix),
		.products(products)
	);

	// Two more register stages inside the tree
	dot_product_adder_tree u_adder_tree (
		.clk(clk),
		.reset(reset),
		.products(products),
		.data_out(data_out)
	);

endmodule

`default_nettype wire

//--- dv/vecmat_checker.sv
`timescale 1ns/1ps
`default_nettype none

module vecmat_checker (
	input  logic clk,
	input  logic reset,
	input  dot_array_pkg::lane_word_t vector,
	input  dot_array_pkg::lane_word_t matrix,
	input  fixed_point_pkg::fixed_t data_out,
	input  logic [3:0] test_id,
	output int check_count,
	output int error_count
);

	import fixed_point_pkg::*;
	import dot_array_pkg::*;

	// Expected results still travelling through the pipeline
	fixed_t expected_q [PIPE_LATENCY];
	logic [3:0] id_q [PIPE_LATENCY];
	int filled = 0;
	int checks = 0;
	int errors = 0;

	assign check_count = checks;
	assign error_count = errors;

	function automatic string test_name(input logic [3:0] id);
		case (id)
			4'd0: return "reset_clear";
			4'd1: return "directed_sums";
			4'd2: return "random_data";
			4'd3: return "multiplier_saturation";
			4'd4: return "adder_saturation";
			4'd5: return "streaming";
			default: return "flush";
		endcase
	endfunction

	function automatic int clamp_q88(input int value);
		if (value > int'(FIXED_MAX)) begin
			return int'(FIXED_MAX);
		end
		if (value < int'(FIXED_MIN)) begin
			return int'(FIXED_MIN);
		end
		return value;
	endfunction

	// Lane products, then pairwise sums of neighbours, level by level
	function automatic fixed_t reference_dot(input lane_word_t vec, input lane_word_t mat);
		int node [LANES];
		int count;
		fixed_t x;
		fixed_t y;
		for (int lane = 0; lane < LANES; lane++) begin
			x = fixed_t'(vec[lane*ELEM_WIDTH +: ELEM_WIDTH]);
			y = fixed_t'(mat[lane*ELEM_WIDTH +: ELEM_WIDTH]);
			node[lane] = clamp_q88((int'(x) * int'(y)) >>> FRAC_BITS);
		end
		count = LANES;
		for (int level = 0; level < TREE_LEVELS; level++) begin
			count = count / 2;
			for (int i = 0; i < count; i++) begin
				node[i] = clamp_q88(node[2*i] + node[2*i+1]);
			end
		end
		return fixed_t'(node[0]);
	endfunction

	always @(posedge clk) begin
		if (filled == PIPE_LATENCY) begin
			checks++;
			if (data_out !== expected_q[PIPE_LATENCY-1]) begin
				errors++;
				$display("Fail %s at %0t: expected %0d, actual %0d",
					test_name(id_q[PIPE_LATENCY-1]), $time,
					expected_q[PIPE_LATENCY-1], data_out);
			end
		end else begin
			filled++;
		end
		for (int i = PIPE_LATENCY - 1; i > 0; i--) begin
			expected_q[i] = expected_q[i-1];
			id_q[i] = id_q[i-1];
		end
		if (!reset) begin
			expected_q[0] = '0;
		end else begin
			expected_q[0] = reference_dot(vector, matrix);
		end
		id_q[0] = test_id;
	end

endmodule

`default_nettype wire

//--- dv/vecmat_properties.sv
`timescale 1ns/1ps
`default_nettype none

module vecmat_properties (
	input logic clk,
	input logic reset,
	input fixed_point_pkg::fixed_t data_out
);

	// Counts edges with reset high and stops at three
	logic [1:0] settle_count;
	int failure_count = 0;

	always_ff @(posedge clk) begin
		if (!reset) begin
			settle_count <= '0;
		end else if (settle_count != 2'd3) begin
			settle_count <= settle_count + 2'd1;
		end
	end

	// Reset edge clears the output register
	reset_clears_output: assert property (@(posedge clk) !reset |=> data_out == '0)
		else begin
			$error("data_out is not zero on the edge after a reset edge");
			failure_count++;
		end

	// Pipeline fully flushed of unknowns
	output_is_known: assert property (@(posedge clk)
		settle_count == 2'd3 |-> !$isunknown(data_out))
		else begin
			$error("data_out carries X or Z after the pipeline has settled");
			failure_count++;
		end

endmodule

bind vecmat_dot_unit vecmat_properties u_properties (
	.clk(clk),
	.reset(reset),
	.data_out(data_out)
);

`default_nettype wire

//--- dv/vecmat_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vecmat_tb;

	import fixed_point_pkg::*;
	import dot_array_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam logic [15:0] LFSR_SEED = 16'd7990;
	localparam logic [15:0] LFSR_TAPS = 16'hB400;

	// Q8.8 constants
	localparam int ONE = 256;
	localparam int Q40 = 40 * ONE;
	localparam int Q50 = 50 * ONE;
	localparam int Q60 = 60 * ONE;
	localparam int Q100 = 100 * ONE;
	localparam int Q127 = 127 * ONE;
	localparam int QMIN = -128 * ONE;

	localparam logic [3:0] ID_RESET = 4'd0;
	localparam logic [3:0] ID_DIRECTED = 4'd1;
	localparam logic [3:0] ID_RANDOM = 4'd2;
	localparam logic [3:0] ID_MUL_SAT = 4'd3;
	localparam logic [3:0] ID_ADD_SAT = 4'd4;
	localparam logic [3:0] ID_STREAM = 4'd5;
	localparam logic [3:0] ID_FLUSH = 4'd6;

	localparam int RESET_CYCLES = 3;
	localparam int RESET_TEST_CYCLES = RESET_CYCLES + 2;
	localparam int DIRECTED_CYCLES = 2 + LANES;
	localparam int RANDOM_CYCLES = 300;
	localparam int MUL_SAT_CYCLES = 4;
	localparam int ADD_SAT_CYCLES = 4;
	localparam int STREAM_CYCLES = 40;
	localparam int FLUSH_CYCLES = PIPE_LATENCY + 1;
	localparam int TOTAL_CYCLES = RESET_TEST_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES +
		MUL_SAT_CYCLES + ADD_SAT_CYCLES + STREAM_CYCLES + FLUSH_CYCLES;

	logic clk;
	logic reset;
	lane_word_t vector;
	lane_word_t matrix;
	fixed_t data_out;
	logic [3:0] test_id;
	int check_count;
	int error_count;
	logic [15:0] lfsr_state;

	vecmat_dot_unit dut (
		.clk(clk),
		.reset(reset),
		.vector(vector),
		.matrix(matrix),
		.data_out(data_out)
	);

	vecmat_checker u_checker (
		.clk(clk),
		.reset(reset),
		.vector(vector),
		.matrix(matrix),
		.data_out(data_out),
		.test_id(test_id),
		.check_count(check_count),
		.error_count(error_count)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(2 * TOTAL_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ LFSR_TAPS;
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit
	task automatic take_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Elements in [-2.0, +2.0)
	task automatic random_word(output lane_word_t word);
		int raw;
		word = '0;
		for (int lane = 0; lane < LANES; lane++) begin
			take_bits(10, raw);
			word[lane*ELEM_WIDTH +: ELEM_WIDTH] = fixed_t'(raw - 2 * ONE);
		end
	endtask

	function automatic lane_word_t with_lane(input lane_word_t word, input int lane,
		input int value);
		lane_word_t result;
		result = word;
		result[lane*ELEM_WIDTH +: ELEM_WIDTH] = fixed_t'(value);
		return result;
	endfunction

	function automatic lane_word_t range_word(input lane_word_t word, input int first,
		input int last, input int value);
		lane_word_t result;
		result = word;
		for (int lane = first; lane <= last; lane++) begin
			result = with_lane(result, lane, value);
		end
		return result;
	endfunction

	function automatic lane_word_t fill_word(input int value);
		return range_word('0, 0, LANES - 1, value);
	endfunction

	function automatic lane_word_t alternate_word(input int even_value, input int odd_value);
		lane_word_t result;
		result = '0;
		for (int lane = 0; lane < LANES; lane++) begin
			result = with_lane(result, lane, (lane % 2 == 0) ? even_value : odd_value);
		end
		return result;
	endfunction

	task automatic drive(input lane_word_t vec, input lane_word_t mat, input logic [3:0] id);
		@(negedge clk);
		vector = vec;
		matrix = mat;
		test_id = id;
	endtask

	// Random inputs during reset and for two edges after release
	task automatic apply_reset();
		lane_word_t vec;
		lane_word_t mat;
		random_word(vec);
		random_word(mat);
		vector = vec;
		matrix = mat;
		for (int i = 1; i < RESET_TEST_CYCLES; i++) begin
			random_word(vec);
			random_word(mat);
			drive(vec, mat, ID_RESET);
			if (i == RESET_CYCLES) begin
				reset = 1'b1;
			end
		end
	endtask

	task automatic directed_sums();
		lane_word_t mat;
		int value;
		mat = '0;
		for (int lane = 0; lane < LANES; lane++) begin
			mat = with_lane(mat, lane, (lane % 4 - 1) * ONE);
		end
		drive(fill_word(ONE), mat, ID_DIRECTED);
		for (int lane = 0; lane < LANES; lane++) begin
			mat = with_lane(mat, lane, (lane % 3 - 1) * ONE);
		end
		drive(fill_word(ONE), mat, ID_DIRECTED);
		// Distinct matrix lanes so each live lane gives its own product
		for (int lane = 0; lane < LANES; lane++) begin
			mat = with_lane(mat, lane, 341 + lane * 37);
		end
		// One live lane at a time with negative values on odd lanes
		for (int lane = 0; lane < LANES; lane++) begin
			value = (lane + 1) * 16 + 3;
			if (lane % 2 == 1) begin
				value = -value;
			end
			drive(with_lane('0, lane, value), mat, ID_DIRECTED);
		end
	endtask

	task automatic random_data();
		lane_word_t vec;
		lane_word_t mat;
		repeat (RANDOM_CYCLES) begin
			random_word(vec);
			random_word(mat);
			drive(vec, mat, ID_RANDOM);
		end
	endtask

	task automatic multiplier_saturation();
		drive(fill_word(Q127), alternate_word(Q100, -Q100), ID_MUL_SAT);
		drive(fill_word(Q127), fill_word(Q100), ID_MUL_SAT);
		drive(fill_word(QMIN), fill_word(QMIN), ID_MUL_SAT);
		drive(fill_word(QMIN), alternate_word(Q127, QMIN), ID_MUL_SAT);
	endtask

	// Overflow at levels 1, 1 and 2, then both halves clamped up to level 4
	task automatic adder_saturation();
		drive(fill_word(ONE), range_word(range_word('0, 0, 1, Q100), 2, 3, -Q60), ID_ADD_SAT);
		drive(fill_word(ONE), range_word(range_word('0, 0, 1, -Q100), 2, 3, Q60), ID_ADD_SAT);
		drive(fill_word(ONE), range_word(range_word('0, 0, 3, Q50), 4, 7, -Q40), ID_ADD_SAT);
		drive(fill_word(ONE), range_word(fill_word(Q100), 16, 31, -Q100), ID_ADD_SAT);
	endtask

	task automatic streaming();
		for (int c = 1; c <= STREAM_CYCLES; c++) begin
			drive(fill_word(ONE), fill_word(c * 8), ID_STREAM);
		end
		repeat (FLUSH_CYCLES) begin
			drive('0, '0, ID_FLUSH);
		end
	endtask

	initial begin
		reset = 1'b0;
		vector = '0;
		matrix = '0;
		test_id = ID_RESET;
		lfsr_state = LFSR_SEED;
		apply_reset();
		directed_sums();
		random_data();
		multiplier_saturation();
		adder_saturation();
		streaming();
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			check_count, error_count, dut.u_properties.failure_count);
		if (error_count == 0 && dut.u_properties.failure_count == 0 && check_count > 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
design/fixed_point_pkg.sv
design/dot_array_pkg.sv
design/signed_fixed_mul.sv
design/fixed_add_sat.sv
design/lane_multiplier_array.sv
design/dot_product_adder_tree.sv
design/vecmat_dot_unit.sv
dv/vecmat_properties.sv
dv/vecmat_checker.sv
dv/vecmat_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -Wno-fatal --top-module vecmat_tb \
		-f list.f -o vecmat_sim &&
	./obj_dir/vecmat_sim +verilator+error+limit+100 | tee /dev/stderr |
		grep '^\*\* PASS \*\*$' > /dev/null &&
	echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }
